//--- logic/spi_pkg.sv
package spi_pkg;

    localparam int FRAME_BITS  = 16;                 // Bits per SPI frame
    localparam int BIT_CNT_W   = 5;                  // Counts 0..FRAME_BITS
    localparam int SCLK_HALF   = 4;                  // inner_clk cycles per sclk half period
    localparam int RATE_CNT_W  = $clog2(SCLK_HALF);  // Rate counter width
    localparam int QUEUE_DEPTH = 4;                  // Entries per FIFO

    // Frame sequencer states of the master
    typedef enum logic [1:0] {
        IDLE,
        SELECT,
        TRANSFER,
        DONE
    } master_state_t;

endpackage

//--- logic/spi_frame_if.sv
`timescale 1ns/100ps

interface spi_frame_if import spi_pkg::*; ();

    logic                  start;    // One-cycle launch pulse
    logic [FRAME_BITS-1:0] tx_word;  // Valid with start
    logic [FRAME_BITS-1:0] rx_word;  // Valid with done
    logic                  done;     // One-cycle completion pulse

    // Launch side, owns start and tx_word
    modport queue (
        output start,
        output tx_word,
        input  rx_word,
        input  done
    );

    // Shifter side, owns rx_word and done
    modport master (
        input  start,
        input  tx_word,
        output rx_word,
        output done
    );

endinterface

//--- logic/spi_rate_gen.sv
`timescale 1ns/100ps

module spi_rate_gen import spi_pkg::*; (
    input  logic inner_clk,
    input  logic reset,
    input  logic enable,
    output logic tick
);

    logic [RATE_CNT_W-1:0] count;

    // Down counter, reloads on each tick
    always_ff @(posedge inner_clk or posedge reset) begin
        if (reset) begin
            count <= RATE_CNT_W'(SCLK_HALF - 1);
        end else if (!enable) begin
            count <= RATE_CNT_W'(SCLK_HALF - 1);   // Fixed phase at each enable
        end else if (count == '0) begin
            count <= RATE_CNT_W'(SCLK_HALF - 1);
        end else begin
            count <= count - 1'b1;
        end
    end

    // First tick lands SCLK_HALF cycles after enable rises
    assign tick = enable && (count == '0);

endmodule

//--- logic/spi_master.sv
`timescale 1ns/100ps

module spi_master import spi_pkg::*; (
    input  logic        inner_clk,
    input  logic        reset,
    spi_frame_if.master frame,
    output logic        sclk,
    output logic        mosi,
    input  logic        miso,
    output logic        cs_n
);

    master_state_t         state;
    logic [FRAME_BITS-1:0] tx_shift;   // Outgoing word, bit 0 first
    logic [FRAME_BITS-1:0] rx_shift;   // Incoming word, fills from the top
    logic [BIT_CNT_W-1:0]  bit_cnt;    // Rising edges seen this frame
    logic                  rate_en;
    logic                  tick;
    logic                  fall_tick;
    logic                  rise_tick;
    logic                  end_tick;
    logic                  shift_tick;

    spi_rate_gen rate_gen (
        .inner_clk (inner_clk),
        .reset     (reset),
        .enable    (rate_en),
        .tick      (tick)
    );

    // Edge decode, sclk is the phase before the toggle
    assign end_tick   = (state == TRANSFER) && tick && (bit_cnt == FRAME_BITS);
    assign fall_tick  = (state == TRANSFER) && tick && sclk && (bit_cnt != FRAME_BITS);
    assign rise_tick  = (state == TRANSFER) && tick && !sclk;
    assign shift_tick = fall_tick && (bit_cnt != '0);   // First fall keeps bit 0

    always_ff @(posedge inner_clk or posedge reset) begin
        if (reset) begin
            state   <= IDLE;
            cs_n    <= 1'b1;
            sclk    <= 1'b1;
            mosi    <= 1'b0;
            rate_en <= 1'b0;
            bit_cnt <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (frame.start) begin
                        bit_cnt <= '0;
                        state   <= SELECT;
                    end
                end
                SELECT: begin
                    cs_n    <= 1'b0;
                    mosi    <= tx_shift[0];
                    rate_en <= 1'b1;
                    state   <= TRANSFER;
                end
                TRANSFER: begin
                    if (end_tick) begin
                        cs_n    <= 1'b1;       // Deselect half a bit after last rise
                        mosi    <= 1'b0;
                        rate_en <= 1'b0;
                        state   <= DONE;
                    end else if (tick) begin
                        sclk <= ~sclk;
                        if (shift_tick) begin
                            mosi <= tx_shift[1];
                        end
                        if (rise_tick) begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                DONE: begin
                    state <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // Shift registers
    always_ff @(posedge inner_clk) begin
        if ((state == IDLE) && frame.start) begin
            tx_shift <= frame.tx_word;
        end else if (shift_tick) begin
            tx_shift <= {1'b0, tx_shift[FRAME_BITS-1:1]};
        end
        if (rise_tick) begin
            rx_shift <= {miso, rx_shift[FRAME_BITS-1:1]};   // Sample before sclk rises
        end
    end

    assign frame.done    = (state == DONE);
    assign frame.rx_word = rx_shift;

    // Clock parks high whenever the slave is deselected
    a_sclk_idle_high: assert property (
        @(posedge inner_clk) disable iff (reset) cs_n |-> sclk
    );

    // Queue must hold off until the previous frame is done
    a_start_in_idle: assert property (
        @(posedge inner_clk) disable iff (reset) frame.start |-> (state == IDLE)
    );

    a_done_single: assert property (
        @(posedge inner_clk) disable iff (reset) frame.done |=> !frame.done
    );

endmodule

//--- logic/sync_fifo.sv
`timescale 1ns/100ps

module sync_fifo #(
    parameter int DEPTH = 4,
    parameter int WIDTH = 16
) (
    input  logic             inner_clk,
    input  logic             reset,
    input  logic             push,
    input  logic [WIDTH-1:0] push_data,
    input  logic             pop,
    output logic [WIDTH-1:0] pop_data,
    output logic             full,
    output logic             empty
);

    logic [WIDTH-1:0]             mem [DEPTH];
    logic [$clog2(DEPTH)-1:0]     wr_ptr;
    logic [$clog2(DEPTH)-1:0]     rd_ptr;
    logic [$clog2(DEPTH+1)-1:0]   count;
    logic                         push_ok;
    logic                         pop_ok;

    assign push_ok = push && !full;    // Drop writes when full
    assign pop_ok  = pop && !empty;

    always_ff @(posedge inner_clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_ok) begin
                wr_ptr <= (wr_ptr == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
            end
            if (pop_ok) begin
                rd_ptr <= (rd_ptr == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
            end
            if (push_ok && !pop_ok) begin
                count <= count + 1'b1;
            end else if (pop_ok && !push_ok) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge inner_clk) begin
        if (push_ok) begin
            mem[wr_ptr] <= push_data;
        end
    end

    assign pop_data = mem[rd_ptr];     // Head word shown ahead of pop
    assign full     = (count == DEPTH);
    assign empty    = (count == 0);

    a_count_bound: assert property (
        @(posedge inner_clk) disable iff (reset) count <= DEPTH
    );

endmodule

//--- logic/spi_frame_queue.sv
`timescale 1ns/100ps

module spi_frame_queue import spi_pkg::*; (
    input  logic                  inner_clk,
    input  logic                  reset,
    input  logic                  wr_en,
    input  logic [FRAME_BITS-1:0] wr_data,
    output logic                  tx_full,
    input  logic                  rd_en,
    output logic [FRAME_BITS-1:0] rd_data,
    output logic                  rx_empty,
    spi_frame_if.queue            frame
);

    logic tx_empty;
    logic rx_full;
    logic launch;   // Registered start pulse
    logic busy;     // Frame outstanding

    sync_fifo #(
        .DEPTH (QUEUE_DEPTH),
        .WIDTH (FRAME_BITS)
    ) tx_fifo (
        .inner_clk (inner_clk),
        .reset     (reset),
        .push      (wr_en),
        .push_data (wr_data),
        .pop       (launch),          // Head leaves with the start pulse
        .pop_data  (frame.tx_word),
        .full      (tx_full),
        .empty     (tx_empty)
    );

    sync_fifo #(
        .DEPTH (QUEUE_DEPTH),
        .WIDTH (FRAME_BITS)
    ) rx_fifo (
        .inner_clk (inner_clk),
        .reset     (reset),
        .push      (frame.done),
        .push_data (frame.rx_word),
        .pop       (rd_en),
        .pop_data  (rd_data),
        .full      (rx_full),
        .empty     (rx_empty)
    );

    // Launch only with room for the result, one frame in flight
    always_ff @(posedge inner_clk or posedge reset) begin
        if (reset) begin
            launch <= 1'b0;
            busy   <= 1'b0;
        end else begin
            launch <= !tx_empty && !rx_full && !busy && !launch;
            if (launch) begin
                busy <= 1'b1;
            end else if (frame.done) begin
                busy <= 1'b0;
            end
        end
    end

    assign frame.start = launch;

    // A result only comes back for a frame this queue launched
    a_done_when_busy: assert property (
        @(posedge inner_clk) disable iff (reset) frame.done |-> busy
    );

endmodule

//--- logic/spi_subsystem.sv
`timescale 1ns/100ps

module spi_subsystem import spi_pkg::*; (
    input  logic                  inner_clk,
    input  logic                  reset,
    input  logic                  wr_en,
    input  logic [FRAME_BITS-1:0] wr_data,
    output logic                  tx_full,
    input  logic                  rd_en,
    output logic [FRAME_BITS-1:0] rd_data,
    output logic                  rx_empty,
    output logic                  sclk,
    output logic                  mosi,
    input  logic                  miso,
    output logic                  cs_n
);

    spi_frame_if frame_bus ();   // Queue to master link

    spi_frame_queue queue (
        .inner_clk (inner_clk),
        .reset     (reset),
        .wr_en     (wr_en),
        .wr_data   (wr_data),
        .tx_full   (tx_full),
        .rd_en     (rd_en),
        .rd_data   (rd_data),
        .rx_empty  (rx_empty),
        .frame     (frame_bus.queue)
    );

    spi_master master (
        .inner_clk (inner_clk),
        .reset     (reset),
        .frame     (frame_bus.master),
        .sclk      (sclk),
        .mosi      (mosi),
        .miso      (miso),
        .cs_n      (cs_n)
    );

endmodule

//--- sim/spi_slave_model.sv
`timescale 1ns/100ps

module spi_slave_model import spi_pkg::*; (
    input  logic                  sclk,
    input  logic                  mosi,
    input  logic                  cs_n,
    output logic                  miso,
    output logic [FRAME_BITS-1:0] captured,     // Word received in the last frame
    output int                    frame_count,  // Completed cs_n windows
    output int                    format_errs   // Bad windows and stray clocks
);

    logic [FRAME_BITS-1:0] shift_reg = '0;
    int                    edge_count = 0;
    logic                  active = 1'b0;     // Inside a real cs_n low window

    initial begin
        miso        = 1'b0;
        captured    = '0;
        frame_count = 0;
        format_errs = 0;
    end

    always @(negedge cs_n) begin
        if (cs_n === 1'b0) begin
            active     = 1'b1;
            edge_count = 0;
            miso       = shift_reg[0];          // Bit 0 ready before the first fall
        end
    end

    // Mode 3, new data on the falling edge
    always @(negedge sclk) begin
        if (cs_n === 1'b1) begin
            format_errs++;
            $display("Slave saw an sclk pulse while cs_n was high at %0t", $time);
        end else begin
            miso = shift_reg[0];
        end
    end

    always @(posedge sclk) begin
        if (cs_n === 1'b0) begin
            shift_reg  = {mosi, shift_reg[FRAME_BITS-1:1]};
            edge_count++;
        end
    end

    always @(posedge cs_n) begin
        if (active) begin
            if (edge_count != FRAME_BITS) begin
                format_errs++;
                $display("Slave frame had %0d sclk edges instead of %0d at %0t",
                         edge_count, FRAME_BITS, $time);
            end
            captured = shift_reg;
            frame_count++;
            active   = 1'b0;
        end
    end

endmodule

//--- sim/spi_subsystem_tb.sv
`timescale 1ns/100ps

module spi_subsystem_tb import spi_pkg::*; ();

    localparam int FRAME_CYCLES   = 2 + (2 * FRAME_BITS + 1) * SCLK_HALF;  // Start to done
    localparam int TIMEOUT_CYCLES = 50 * (FRAME_CYCLES + 16);

    logic                  inner_clk;
    logic                  reset;
    logic                  wr_en;
    logic [FRAME_BITS-1:0] wr_data;
    logic                  tx_full;
    logic                  rd_en;
    logic [FRAME_BITS-1:0] rd_data;
    logic                  rx_empty;
    logic                  sclk;
    logic                  mosi;
    logic                  miso;
    logic                  cs_n;
    logic [FRAME_BITS-1:0] slave_word;
    int                    slave_frames;
    int                    slave_errs;

    int                    err_count = 0;
    int                    check_count = 0;
    int                    cycle_count = 0;
    int                    sent_frames = 0;   // Writes the DUT must accept
    logic [FRAME_BITS-1:0] prev_sent = '0;    // Slave echoes this in the next frame
    logic [FRAME_BITS-1:0] expect_q [$];

    spi_subsystem uut (
        .inner_clk (inner_clk),
        .reset     (reset),
        .wr_en     (wr_en),
        .wr_data   (wr_data),
        .tx_full   (tx_full),
        .rd_en     (rd_en),
        .rd_data   (rd_data),
        .rx_empty  (rx_empty),
        .sclk      (sclk),
        .mosi      (mosi),
        .miso      (miso),
        .cs_n      (cs_n)
    );

    spi_slave_model slave (
        .sclk        (sclk),
        .mosi        (mosi),
        .cs_n        (cs_n),
        .miso        (miso),
        .captured    (slave_word),
        .frame_count (slave_frames),
        .format_errs (slave_errs)
    );

    initial begin
        inner_clk = 1'b0;
        forever #20 inner_clk = ~inner_clk;
    end

    // Watchdog
    always @(posedge inner_clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the DUT stopped responding", cycle_count);
            $display("Summary: %0d checks, %0d errors", check_count, err_count);
            $display(">>> FAIL");
            $finish;
        end
    end

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        check_count++;
        assert (got === exp) else begin
            err_count++;
            $display("ERR t=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic confirm(input bit cond, input string what);
        check_count++;
        assert (cond) else begin
            err_count++;
            $display("Check failed at %0t: %s", $time, what);
        end
    endtask

    // One write cycle, no bookkeeping
    task automatic drive_write(input logic [FRAME_BITS-1:0] word);
        wr_en   = 1'b1;
        wr_data = word;
        @(posedge inner_clk);
        #2;
        wr_en = 1'b0;
    endtask

    task automatic write_word(input logic [FRAME_BITS-1:0] word);
        while (tx_full) begin
            @(posedge inner_clk);
            #2;
        end
        drive_write(word);
        expect_q.push_back(prev_sent);   // Result lags the sent word by one frame
        prev_sent = word;
        sent_frames++;
    endtask

    task automatic wait_for_result();
        while (rx_empty) begin
            @(posedge inner_clk);
            #2;
        end
    endtask

    task automatic read_result();
        logic [FRAME_BITS-1:0] exp;
        wait_for_result();
        exp = expect_q.pop_front();
        compare_value("rd_data", rd_data, exp);
        rd_en = 1'b1;
        @(posedge inner_clk);
        #2;
        rd_en = 1'b0;
    endtask

    task automatic wait_for_frames(input int count);
        while (slave_frames < count) begin
            @(posedge inner_clk);
            #2;
        end
    endtask

    // cs_n must stay high for the whole window
    task automatic hold_quiet(input int cycles);
        int low_cycles;
        low_cycles = 0;
        repeat (cycles) begin
            @(posedge inner_clk);
            #2;
            if (!cs_n) low_cycles++;
        end
        confirm(low_cycles == 0, "a frame started while the bus should have stayed idle");
    endtask

    task automatic reset_state();
        compare_value("cs_n", cs_n, 1'b1);
        compare_value("sclk", sclk, 1'b1);
        compare_value("mosi", mosi, 1'b0);
        compare_value("tx_full", tx_full, 1'b0);
        compare_value("rx_empty", rx_empty, 1'b1);
    endtask

    task automatic single_frame();
        write_word(16'ha5c3);
        wait_for_result();
        compare_value("rd_data", rd_data, 16'h0000);   // Slave starts empty
        compare_value("slave_word", slave_word, 16'ha5c3);
        read_result();
    endtask

    task automatic burst_in_order();
        logic [FRAME_BITS-1:0] words [4];
        words = '{16'h1234, 16'h8001, 16'hfedc, 16'h0f0f};
        foreach (words[i]) write_word(words[i]);
        repeat (4) read_result();
        compare_value("slave_frames", slave_frames, sent_frames);
        compare_value("slave_errs", slave_errs, 0);
        compare_value("slave_word", slave_word, words[3]);
    endtask

    task automatic back_pressure();
        for (int i = 0; i < 8; i++) begin
            write_word(16'hb000 + i);
        end
        wait_for_frames(sent_frames - 4);   // Receive side now full
        hold_quiet(FRAME_CYCLES);
        compare_value("tx_full", tx_full, 1'b1);
        compare_value("slave_frames", slave_frames, sent_frames - 4);
        drive_write(16'hdead);              // Dropped since the queue is full
        compare_value("tx_full", tx_full, 1'b1);
        repeat (8) read_result();
        hold_quiet(FRAME_CYCLES);
        compare_value("rx_empty", rx_empty, 1'b1);
        compare_value("slave_frames", slave_frames, sent_frames);
        compare_value("slave_word", slave_word, prev_sent);
    endtask

    task automatic random_traffic();
        logic [FRAME_BITS-1:0] word;
        for (int i = 0; i < 20; i++) begin
            word = FRAME_BITS'($urandom);
            write_word(word);
            // Bounded backlog keeps both queues from locking up
            if (expect_q.size() >= 3 || $urandom_range(1, 0) == 1) read_result();
        end
        while (expect_q.size() != 0) read_result();
        compare_value("rx_empty", rx_empty, 1'b1);
        compare_value("slave_frames", slave_frames, sent_frames);
        compare_value("slave_errs", slave_errs, 0);
    endtask

    initial begin
        void'($urandom(32'hbdd79bad));
        reset   = 1'b1;
        wr_en   = 1'b0;
        wr_data = '0;
        rd_en   = 1'b0;
        repeat (4) @(posedge inner_clk);
        #2;
        reset = 1'b0;

        reset_state();
        single_frame();
        burst_in_order();
        back_pressure();
        random_traffic();

        $display("Summary: %0d checks, %0d errors", check_count, err_count);
        if (err_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- spi_subsystem.f
logic/spi_pkg.sv
logic/spi_frame_if.sv
logic/spi_rate_gen.sv
logic/spi_master.sv
logic/sync_fifo.sv
logic/spi_frame_queue.sv
logic/spi_subsystem.sv
sim/spi_slave_model.sv
sim/spi_subsystem_tb.sv

//--- Bender.yml
package:
  name: spi_subsystem

sources:
  - logic/spi_pkg.sv
  - logic/spi_frame_if.sv
  - logic/spi_rate_gen.sv
  - logic/spi_master.sv
  - logic/sync_fifo.sv
  - logic/spi_frame_queue.sv
  - logic/spi_subsystem.sv
  - target: simulation
    files:
      - sim/spi_slave_model.sv
      - sim/spi_subsystem_tb.sv
